// ==== hdl/alpha_pkg.sv ====
// integer pipeline shared definitions

package alpha_pkg;

	// ************************************************************************
	// vector types
	// ************************************************************************
	typedef logic [31:0] inst_t;        // instruction word
	typedef logic [63:0] word_t;        // register value
	typedef logic [4:0]  reg_idx_t;     // register index
	typedef logic [4:0]  alu_func_t;    // alu operation
	typedef logic [2:0]  fu_sel_t;      // functional unit class
	typedef logic [1:0]  opa_sel_t;
	typedef logic [1:0]  opb_sel_t;
	typedef logic [1:0]  dest_sel_t;

	// ************************************************************************
	// opcodes, inst[31:26]
	// ************************************************************************
	localparam logic [5:0] PAL_INST   = 6'h00;
	localparam logic [5:0] LDA_INST   = 6'h08;
	localparam logic [5:0] INTA_GRP   = 6'h10;  // arithmetic and compares
	localparam logic [5:0] INTL_GRP   = 6'h11;  // logical
	localparam logic [5:0] INTS_GRP   = 6'h12;  // shifts
	localparam logic [5:0] INTM_GRP   = 6'h13;  // multiply
	localparam logic [5:0] JSR_GRP    = 6'h1a;  // jmp, jsr, ret, jsr_co
	localparam logic [5:0] LDQ_INST   = 6'h29;
	localparam logic [5:0] LDQ_L_INST = 6'h2b;
	localparam logic [5:0] STQ_INST   = 6'h2d;
	localparam logic [5:0] STQ_C_INST = 6'h2f;
	localparam logic [5:0] BR_INST    = 6'h30;
	localparam logic [5:0] BSR_INST   = 6'h34;
	localparam logic [5:0] BLBC_INST  = 6'h38;
	localparam logic [5:0] BEQ_INST   = 6'h39;
	localparam logic [5:0] BLT_INST   = 6'h3a;
	localparam logic [5:0] BLE_INST   = 6'h3b;
	localparam logic [5:0] BLBS_INST  = 6'h3c;
	localparam logic [5:0] BNE_INST   = 6'h3d;
	localparam logic [5:0] BGE_INST   = 6'h3e;
	localparam logic [5:0] BGT_INST   = 6'h3f;

	// function codes, inst[11:5], reused across groups
	localparam logic [6:0] ADDQ_INST   = 7'h20;
	localparam logic [6:0] SUBQ_INST   = 7'h29;
	localparam logic [6:0] CMPULT_INST = 7'h1d;
	localparam logic [6:0] CMPEQ_INST  = 7'h2d;
	localparam logic [6:0] CMPULE_INST = 7'h3d;
	localparam logic [6:0] CMPLT_INST  = 7'h4d;
	localparam logic [6:0] CMPLE_INST  = 7'h6d;
	localparam logic [6:0] AND_INST    = 7'h00;
	localparam logic [6:0] BIC_INST    = 7'h08;
	localparam logic [6:0] BIS_INST    = 7'h20;
	localparam logic [6:0] ORNOT_INST  = 7'h28;
	localparam logic [6:0] XOR_INST    = 7'h40;
	localparam logic [6:0] EQV_INST    = 7'h48;
	localparam logic [6:0] SRL_INST    = 7'h34;
	localparam logic [6:0] SLL_INST    = 7'h39;
	localparam logic [6:0] SRA_INST    = 7'h3c;
	localparam logic [6:0] MULQ_INST   = 7'h20;

	localparam alu_func_t ALU_ADDQ   = 5'd0;
	localparam alu_func_t ALU_SUBQ   = 5'd1;
	localparam alu_func_t ALU_AND    = 5'd2;
	localparam alu_func_t ALU_BIC    = 5'd3;
	localparam alu_func_t ALU_BIS    = 5'd4;
	localparam alu_func_t ALU_ORNOT  = 5'd5;
	localparam alu_func_t ALU_XOR    = 5'd6;
	localparam alu_func_t ALU_EQV    = 5'd7;
	localparam alu_func_t ALU_SRL    = 5'd8;
	localparam alu_func_t ALU_SLL    = 5'd9;
	localparam alu_func_t ALU_SRA    = 5'd10;
	localparam alu_func_t ALU_MULQ   = 5'd11;
	localparam alu_func_t ALU_CMPULT = 5'd12;
	localparam alu_func_t ALU_CMPEQ  = 5'd13;
	localparam alu_func_t ALU_CMPULE = 5'd14;
	localparam alu_func_t ALU_CMPLT  = 5'd15;
	localparam alu_func_t ALU_CMPLE  = 5'd16;

	localparam logic [25:0] PAL_HALT  = 26'h0000000;
	localparam logic [25:0] PAL_WHAMI = 26'h000003c;

	localparam reg_idx_t ZERO_REG = 5'd31;
	localparam word_t    CPU_ID   = 64'h0000_0000_0000_0001;

	// mux selects
	localparam opa_sel_t  OPA_IS_REGA     = 2'd0;
	localparam opa_sel_t  OPA_IS_MEM_DISP = 2'd1;
	localparam opa_sel_t  OPA_IS_NOT3     = 2'd2;
	localparam opb_sel_t  OPB_IS_REGB     = 2'd0;
	localparam opb_sel_t  OPB_IS_ALU_IMM  = 2'd1;
	localparam opb_sel_t  OPB_IS_BR_DISP  = 2'd2;
	localparam dest_sel_t DEST_NONE       = 2'd0;
	localparam dest_sel_t DEST_IS_REGC    = 2'd1;
	localparam dest_sel_t DEST_IS_REGA    = 2'd2;

	localparam fu_sel_t FU_NONE          = 3'd0;
	localparam fu_sel_t FU_ALU           = 3'd1;
	localparam fu_sel_t FU_MULT          = 3'd2;
	localparam fu_sel_t FU_LOAD          = 3'd3;
	localparam fu_sel_t FU_STORE         = 3'd4;
	localparam fu_sel_t FU_COND_BRANCH   = 3'd5;
	localparam fu_sel_t FU_UNCOND_BRANCH = 3'd6;

	// ************************************************************************
	// pipeline packets
	// ************************************************************************
	typedef struct packed {
		inst_t     inst;
		reg_idx_t  ra_idx;          // ZERO_REG when opa is not a register
		reg_idx_t  rb_idx;
		reg_idx_t  dest_idx;        // ZERO_REG when no writeback
		opa_sel_t  opa_sel;
		opb_sel_t  opb_sel;
		alu_func_t alu_func;
		fu_sel_t   fu_sel;
		logic      rd_mem;
		logic      wr_mem;
		logic      ldl_mem;
		logic      stc_mem;
		logic      cond_branch;
		logic      uncond_branch;
		logic      halt;
		logic      cpuid;
		logic      illegal;
	} id_pkt_t;

	typedef struct packed {
		reg_idx_t dest_idx;
		word_t    value;            // result, address or target
		fu_sel_t  fu_sel;
		logic     taken;
		logic     halt;
		logic     illegal;
	} ret_pkt_t;

endpackage

// ==== hdl/inst_decoder.sv ====
// instruction decoder

`timescale 1ns/1ps

module inst_decoder (
	input  alpha_pkg::inst_t     inst_i,
	input  logic                 valid_i,          // noop outputs when low
	output alpha_pkg::opa_sel_t  opa_sel_o,
	output alpha_pkg::opb_sel_t  opb_sel_o,
	output alpha_pkg::dest_sel_t dest_sel_o,
	output alpha_pkg::alu_func_t alu_func_o,
	output alpha_pkg::fu_sel_t   fu_sel_o,
	output logic                 rd_mem_o,
	output logic                 wr_mem_o,
	output logic                 ldl_mem_o,
	output logic                 stc_mem_o,
	output logic                 cond_branch_o,
	output logic                 uncond_branch_o,
	output logic                 halt_o,
	output logic                 cpuid_o,
	output logic                 illegal_o
);
	import alpha_pkg::*;

	logic [5:0] opcode;
	logic [6:0] func;

	assign opcode = inst_i[31:26];
	assign func   = inst_i[11:5];

	always_comb
	begin
		// noop defaults, each class overrides what it needs
		opa_sel_o       = OPA_IS_REGA;
		opb_sel_o       = OPB_IS_REGB;
		alu_func_o      = ALU_ADDQ;
		dest_sel_o      = DEST_NONE;
		fu_sel_o        = FU_NONE;
		rd_mem_o        = 1'b0;
		wr_mem_o        = 1'b0;
		ldl_mem_o       = 1'b0;
		stc_mem_o       = 1'b0;
		cond_branch_o   = 1'b0;
		uncond_branch_o = 1'b0;
		halt_o          = 1'b0;
		cpuid_o         = 1'b0;
		illegal_o       = 1'b0;
		if (valid_i)
		begin
			case ({opcode[5:3], 3'b000})                    // coarse class first
				6'h00:
				begin
					if (opcode != PAL_INST)
						illegal_o = 1'b1;
					else if (inst_i[25:0] == PAL_HALT)
						halt_o = 1'b1;
					else if (inst_i[25:0] == PAL_WHAMI)
					begin
						cpuid_o    = 1'b1;
						dest_sel_o = DEST_IS_REGA;          // id lands in ra
					end
					else
						illegal_o = 1'b1;                   // other pal codes
				end
				6'h10:
				begin
					opb_sel_o  = inst_i[12] ? OPB_IS_ALU_IMM : OPB_IS_REGB;  // literal form
					dest_sel_o = DEST_IS_REGC;
					fu_sel_o   = FU_ALU;
					case (opcode)
						INTA_GRP:
							case (func)
								ADDQ_INST:   alu_func_o = ALU_ADDQ;
								SUBQ_INST:   alu_func_o = ALU_SUBQ;
								CMPULT_INST: alu_func_o = ALU_CMPULT;
								CMPEQ_INST:  alu_func_o = ALU_CMPEQ;
								CMPULE_INST: alu_func_o = ALU_CMPULE;
								CMPLT_INST:  alu_func_o = ALU_CMPLT;
								CMPLE_INST:  alu_func_o = ALU_CMPLE;
								default:     illegal_o  = 1'b1;
							endcase
						INTL_GRP:
							case (func)
								AND_INST:    alu_func_o = ALU_AND;
								BIC_INST:    alu_func_o = ALU_BIC;
								BIS_INST:    alu_func_o = ALU_BIS;
								ORNOT_INST:  alu_func_o = ALU_ORNOT;
								XOR_INST:    alu_func_o = ALU_XOR;
								EQV_INST:    alu_func_o = ALU_EQV;
								default:     illegal_o  = 1'b1;
							endcase
						INTS_GRP:
							case (func)
								SRL_INST:    alu_func_o = ALU_SRL;
								SLL_INST:    alu_func_o = ALU_SLL;
								SRA_INST:    alu_func_o = ALU_SRA;
								default:     illegal_o  = 1'b1;
							endcase
						INTM_GRP:
						begin
							fu_sel_o = FU_MULT;
							if (func == MULQ_INST)
								alu_func_o = ALU_MULQ;
							else
								illegal_o = 1'b1;
						end
						default: illegal_o = 1'b1;          // fp groups
					endcase
				end
				6'h18:
				begin
					if (opcode == JSR_GRP)
					begin
						opa_sel_o       = OPA_IS_NOT3;
						alu_func_o      = ALU_AND;          // word-align rb
						dest_sel_o      = DEST_IS_REGA;
						uncond_branch_o = 1'b1;
						fu_sel_o        = FU_UNCOND_BRANCH;
					end
					else
						illegal_o = 1'b1;                   // misc, fp moves
				end
				6'h08, 6'h20, 6'h28:
				begin
					opa_sel_o  = OPA_IS_MEM_DISP;
					dest_sel_o = DEST_IS_REGA;
					case (opcode)
						LDA_INST: fu_sel_o = FU_ALU;
						LDQ_INST:
						begin
							rd_mem_o = 1'b1;
							fu_sel_o = FU_LOAD;
						end
						LDQ_L_INST:
						begin
							rd_mem_o  = 1'b1;
							ldl_mem_o = 1'b1;
							fu_sel_o  = FU_LOAD;
						end
						STQ_INST:
						begin
							wr_mem_o   = 1'b1;
							opa_sel_o  = OPA_IS_REGA;       // ra carries store data
							dest_sel_o = DEST_NONE;
							fu_sel_o   = FU_STORE;
						end
						STQ_C_INST:
						begin
							wr_mem_o  = 1'b1;
							stc_mem_o = 1'b1;
							fu_sel_o  = FU_STORE;
						end
						default: illegal_o = 1'b1;          // fp loads/stores, ldah etc
					endcase
				end
				default:
				begin
					// 6'h30 and 6'h38, branch formats
					opb_sel_o = OPB_IS_BR_DISP;
					case (opcode)
						BR_INST, BSR_INST:
						begin
							dest_sel_o      = DEST_IS_REGA;
							uncond_branch_o = 1'b1;
							fu_sel_o        = FU_UNCOND_BRANCH;
						end
						BEQ_INST, BNE_INST, BLT_INST, BLE_INST,
						BGT_INST, BGE_INST, BLBC_INST, BLBS_INST:
						begin
							cond_branch_o = 1'b1;
							fu_sel_o      = FU_COND_BRANCH;
						end
						default: illegal_o = 1'b1;          // fp conditionals
					endcase
				end
			endcase
		end
	end

endmodule

// ==== hdl/id_stage.sv ====
// decode stage

`timescale 1ns/1ps

module id_stage (
	input  logic                clk,
	input  logic                rst_n_i,
	input  alpha_pkg::inst_t    inst_i,
	input  logic                inst_valid_i,
	input  logic                halted_i,      // core stopped, refuse input
	input  logic                ex_ready_i,
	output logic                inst_ready_o,
	output logic                id_valid_o,
	output alpha_pkg::id_pkt_t  id_pkt_o
);
	import alpha_pkg::*;

	id_pkt_t   pkt_next;
	opa_sel_t  opa_sel;
	opb_sel_t  opb_sel;
	dest_sel_t dest_sel;

	inst_decoder u_dec (
		.inst_i          (inst_i),
		.valid_i         (inst_valid_i),
		.opa_sel_o       (opa_sel),
		.opb_sel_o       (opb_sel),
		.dest_sel_o      (dest_sel),
		.alu_func_o      (pkt_next.alu_func),
		.fu_sel_o        (pkt_next.fu_sel),
		.rd_mem_o        (pkt_next.rd_mem),
		.wr_mem_o        (pkt_next.wr_mem),
		.ldl_mem_o       (pkt_next.ldl_mem),
		.stc_mem_o       (pkt_next.stc_mem),
		.cond_branch_o   (pkt_next.cond_branch),
		.uncond_branch_o (pkt_next.uncond_branch),
		.halt_o          (pkt_next.halt),
		.cpuid_o         (pkt_next.cpuid),
		.illegal_o       (pkt_next.illegal)
	);

	// index muxes, unused operands point at r31
	assign pkt_next.inst    = inst_i;
	assign pkt_next.opa_sel = opa_sel;
	assign pkt_next.opb_sel = opb_sel;
	assign pkt_next.ra_idx  = (opa_sel == OPA_IS_REGA) ? inst_i[25:21] : ZERO_REG;
	assign pkt_next.rb_idx  = (opb_sel == OPB_IS_REGB) ? inst_i[20:16] : ZERO_REG;

	always_comb
	begin
		case (dest_sel)
			DEST_IS_REGC: pkt_next.dest_idx = inst_i[4:0];
			DEST_IS_REGA: pkt_next.dest_idx = inst_i[25:21];
			default:      pkt_next.dest_idx = ZERO_REG;   // no writeback
		endcase
	end

	assign inst_ready_o = !halted_i && (!id_valid_o || ex_ready_i);   // empty or draining

	always_ff @(posedge clk)
	begin
		if (!rst_n_i || halted_i)                         // halt drops whatever is held
		begin
			id_valid_o <= 1'b0;
			id_pkt_o   <= '0;
		end
		else if (inst_ready_o)
		begin
			id_valid_o <= inst_valid_i;
			if (inst_valid_i)
				id_pkt_o <= pkt_next;
		end
	end

endmodule

// ==== hdl/reg_file.sv ====
// integer register file

`timescale 1ns/1ps

module reg_file (
	input  logic                clk,
	input  logic                rst_n_i,
	input  alpha_pkg::reg_idx_t ra_idx_i,
	input  alpha_pkg::reg_idx_t rb_idx_i,
	input  logic                we_i,
	input  alpha_pkg::reg_idx_t wr_idx_i,
	input  alpha_pkg::word_t    wr_data_i,
	output alpha_pkg::word_t    ra_data_o,
	output alpha_pkg::word_t    rb_data_o
);
	import alpha_pkg::*;

	word_t regs [32];

	// combinational reads, r31 hardwired
	assign ra_data_o = (ra_idx_i == ZERO_REG) ? '0 : regs[ra_idx_i];
	assign rb_data_o = (rb_idx_i == ZERO_REG) ? '0 : regs[rb_idx_i];

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we_i && (wr_idx_i != ZERO_REG))          // r31 writes dropped
			regs[wr_idx_i] <= wr_data_i;
	end

endmodule

// ==== hdl/ex_stage.sv ====
// execute stage

`timescale 1ns/1ps

module ex_stage (
	input  logic                id_valid_i,
	input  alpha_pkg::id_pkt_t  id_pkt_i,
	input  alpha_pkg::word_t    ra_data_i,
	input  alpha_pkg::word_t    rb_data_i,
	output logic                ex_valid_o,
	output alpha_pkg::ret_pkt_t ex_ret_o
);
	import alpha_pkg::*;

	inst_t inst;
	word_t mem_disp, alu_imm, br_disp;
	word_t opa, opb, alu_res;

	assign inst       = id_pkt_i.inst;
	assign ex_valid_o = id_valid_i;                    // no latency here

	assign mem_disp = {{48{inst[15]}}, inst[15:0]};         // sign-extended
	assign alu_imm  = {56'b0, inst[20:13]};                 // zero-extended literal
	assign br_disp  = {{41{inst[20]}}, inst[20:0], 2'b00};  // longwords to bytes

	always_comb
	begin
		case (id_pkt_i.opa_sel)
			OPA_IS_MEM_DISP: opa = mem_disp;
			OPA_IS_NOT3:     opa = ~64'h3;
			default:         opa = ra_data_i;
		endcase
		case (id_pkt_i.opb_sel)
			OPB_IS_ALU_IMM:  opb = alu_imm;
			OPB_IS_BR_DISP:  opb = br_disp;
			default:         opb = rb_data_i;
		endcase
	end

	// ************************************************************************
	// integer alu
	// ************************************************************************
	always_comb
	begin
		case (id_pkt_i.alu_func)
			ALU_SUBQ:   alu_res = opa - opb;
			ALU_AND:    alu_res = opa & opb;
			ALU_BIC:    alu_res = opa & ~opb;
			ALU_BIS:    alu_res = opa | opb;
			ALU_ORNOT:  alu_res = opa | ~opb;
			ALU_XOR:    alu_res = opa ^ opb;
			ALU_EQV:    alu_res = opa ^ ~opb;
			ALU_SRL:    alu_res = opa >> opb[5:0];
			ALU_SLL:    alu_res = opa << opb[5:0];
			ALU_SRA:    alu_res = word_t'($signed(opa) >>> opb[5:0]);
			ALU_MULQ:   alu_res = opa * opb;                // low 64 bits only
			ALU_CMPULT: alu_res = {63'b0, opa < opb};
			ALU_CMPEQ:  alu_res = {63'b0, opa == opb};
			ALU_CMPULE: alu_res = {63'b0, opa <= opb};
			ALU_CMPLT:  alu_res = {63'b0, $signed(opa) < $signed(opb)};
			ALU_CMPLE:  alu_res = {63'b0, $signed(opa) <= $signed(opb)};
			default:    alu_res = opa + opb;                // addq, addresses, targets
		endcase
	end

	always_comb
	begin
		ex_ret_o.dest_idx = id_pkt_i.dest_idx;
		ex_ret_o.fu_sel   = id_pkt_i.fu_sel;
		ex_ret_o.halt     = id_pkt_i.halt;
		ex_ret_o.illegal  = id_pkt_i.illegal;
		if (id_pkt_i.cpuid)
			ex_ret_o.value = CPU_ID;
		else if (id_pkt_i.wr_mem)
			ex_ret_o.value = mem_disp + opb;            // store address, ra is data
		else
			ex_ret_o.value = alu_res;
		// branch condition on ra
		ex_ret_o.taken = id_pkt_i.uncond_branch;
		if (id_pkt_i.cond_branch)
		begin
			case (inst[31:26])
				BEQ_INST:  ex_ret_o.taken = (ra_data_i == '0);
				BNE_INST:  ex_ret_o.taken = (ra_data_i != '0);
				BLT_INST:  ex_ret_o.taken = ra_data_i[63];
				BLE_INST:  ex_ret_o.taken = ra_data_i[63] || (ra_data_i == '0);
				BGT_INST:  ex_ret_o.taken = !ra_data_i[63] && (ra_data_i != '0);
				BGE_INST:  ex_ret_o.taken = !ra_data_i[63];
				BLBC_INST: ex_ret_o.taken = !ra_data_i[0];
				default:   ex_ret_o.taken = ra_data_i[0];  // blbs
			endcase
		end
	end

endmodule

// ==== hdl/wb_stage.sv ====
// result stage and retire port

`timescale 1ns/1ps

module wb_stage (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                ex_valid_i,
	input  alpha_pkg::ret_pkt_t ex_ret_i,
	input  logic                ret_ready_i,
	output logic                ex_ready_o,
	output logic                ret_valid_o,
	output alpha_pkg::ret_pkt_t ret_o,
	output logic                rf_we_o,
	output alpha_pkg::reg_idx_t rf_idx_o,
	output alpha_pkg::word_t    rf_data_o,
	output logic                halted_o
);
	import alpha_pkg::*;

	logic ret_fire;
	logic capture;

	assign ret_fire = ret_valid_o && ret_ready_i;
	// a held halt record blocks the stage behind it
	assign ex_ready_o = !halted_o && (!ret_valid_o || (ret_ready_i && !ret_o.halt));
	assign capture    = ex_valid_i && ex_ready_o;

	// register write rides on capture, so the next decode sees it
	assign rf_we_o   = capture && (ex_ret_i.dest_idx != ZERO_REG) && !ex_ret_i.illegal;
	assign rf_idx_o  = ex_ret_i.dest_idx;
	assign rf_data_o = ex_ret_i.value;

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			ret_valid_o <= 1'b0;
			ret_o       <= '0;
			halted_o    <= 1'b0;
		end
		else
		begin
			if (ret_fire)
				ret_valid_o <= 1'b0;
			if (ret_fire && ret_o.halt)
				halted_o <= 1'b1;                          // sticky until reset
			if (capture)
			begin
				ret_valid_o <= 1'b1;
				ret_o       <= ex_ret_i;
			end
		end
	end

endmodule

// ==== hdl/int_core.sv ====
// integer core top level

`timescale 1ns/1ps

module int_core (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic                inst_valid_i,
	input  alpha_pkg::inst_t    inst_i,
	output logic                inst_ready_o,
	output logic                ret_valid_o,
	output alpha_pkg::ret_pkt_t ret_o,
	input  logic                ret_ready_i,
	output logic                halted_o
);
	import alpha_pkg::*;

	logic     id_valid;
	id_pkt_t  id_pkt;
	word_t    ra_data, rb_data;
	logic     ex_valid;
	ret_pkt_t ex_ret;
	logic     ex_ready;
	logic     rf_we;
	reg_idx_t rf_idx;
	word_t    rf_data;

	id_stage u_id (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.inst_i       (inst_i),
		.inst_valid_i (inst_valid_i),
		.halted_i     (halted_o),
		.ex_ready_i   (ex_ready),
		.inst_ready_o (inst_ready_o),
		.id_valid_o   (id_valid),
		.id_pkt_o     (id_pkt)
	);

	reg_file u_rf (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.ra_idx_i  (id_pkt.ra_idx),                     // read from the id register
		.rb_idx_i  (id_pkt.rb_idx),
		.we_i      (rf_we),
		.wr_idx_i  (rf_idx),
		.wr_data_i (rf_data),
		.ra_data_o (ra_data),
		.rb_data_o (rb_data)
	);

	ex_stage u_ex (
		.id_valid_i (id_valid),
		.id_pkt_i   (id_pkt),
		.ra_data_i  (ra_data),
		.rb_data_i  (rb_data),
		.ex_valid_o (ex_valid),
		.ex_ret_o   (ex_ret)
	);

	wb_stage u_wb (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.ex_valid_i  (ex_valid),
		.ex_ret_i    (ex_ret),
		.ret_ready_i (ret_ready_i),
		.ex_ready_o  (ex_ready),
		.ret_valid_o (ret_valid_o),
		.ret_o       (ret_o),
		.rf_we_o     (rf_we),
		.rf_idx_o    (rf_idx),
		.rf_data_o   (rf_data),
		.halted_o    (halted_o)
	);

endmodule

// ==== verif/int_core_asserts.sv ====
// retire port and halt checker

`timescale 1ns/1ps

module int_core_asserts (
	input logic                clk,
	input logic                rst_n_i,
	input logic                inst_ready_o,
	input logic                ret_valid_o,
	input alpha_pkg::ret_pkt_t ret_o,
	input logic                ret_ready_i,
	input logic                halted_o
);
	import alpha_pkg::*;

	int fail_cnt = 0;                                  // failed assertions so far

	// a stalled record keeps valid and data
	stall_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
		ret_valid_o && !ret_ready_i |=> ret_valid_o && $stable(ret_o))
	else
	begin
		$error("retire record changed while stalled");
		fail_cnt++;
	end

	// no new work once stopped
	halt_blocks_input: assert property (@(posedge clk) disable iff (!rst_n_i)
		halted_o |-> !inst_ready_o)
	else
	begin
		$error("inst_ready_o high while halted");
		fail_cnt++;
	end

	reset_clears_ret: assert property (@(posedge clk) !rst_n_i |=> !ret_valid_o)
	else
	begin
		$error("ret_valid_o seen during reset");
		fail_cnt++;
	end

endmodule

bind int_core int_core_asserts u_asserts (.*);

// ==== verif/int_core_tb.sv ====
// integer core testbench

`timescale 1ns/1ps

module int_core_tb;
	import alpha_pkg::*;

	localparam int N_INT  = 200;
	localparam int N_MEM  = 100;
	localparam int N_SPEC = 40;
	localparam int N_BP   = 200;
	localparam int N_HALT = 21;
	localparam int CYCLE_LIMIT = (N_INT + N_MEM + N_SPEC + N_BP + N_HALT) * 8 + 200;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic     clk;
	logic     rst_n_i;
	logic     inst_valid_i;
	inst_t    inst_i;
	logic     inst_ready_o;
	logic     ret_valid_o;
	ret_pkt_t ret_o;
	logic     ret_ready_i;
	logic     halted_o;

	logic [31:0] lfsr = 32'h999b7347;
	word_t       regs [32];                              // model register file
	ret_pkt_t    exp_q [$];
	logic        stall_en = 1'b0;
	int          err_cnt = 0;
	int          rec_cnt = 0;
	int          cycles = 0;

	int_core dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("run stopped: cycle limit reached before the tests finished");
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// ************************************************************************
	// stimulus helpers
	// ************************************************************************
	function automatic logic [31:0] take_bits(int n);
		logic [31:0] r;
		logic        b;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			b    = lfsr[0];                                // one step per bit
			lfsr = b ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
			r    = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic inst_t op_inst(logic [5:0] opc, logic [6:0] fn);
		logic [4:0] ra, rb, rc;
		ra = 5'(take_bits(5));
		rb = 5'(take_bits(5));
		rc = 5'(take_bits(5));
		if (take_bits(1))
			return {opc, ra, 8'(take_bits(8)), 1'b1, fn, rc};      // literal form
		return {opc, ra, rb, 3'b000, 1'b0, fn, rc};
	endfunction

	function automatic inst_t int_op(int k);
		case (k)
			0:  return op_inst(INTA_GRP, ADDQ_INST);
			1:  return op_inst(INTA_GRP, SUBQ_INST);
			2:  return op_inst(INTA_GRP, CMPULT_INST);
			3:  return op_inst(INTA_GRP, CMPEQ_INST);
			4:  return op_inst(INTA_GRP, CMPULE_INST);
			5:  return op_inst(INTA_GRP, CMPLT_INST);
			6:  return op_inst(INTA_GRP, CMPLE_INST);
			7:  return op_inst(INTL_GRP, AND_INST);
			8:  return op_inst(INTL_GRP, BIC_INST);
			9:  return op_inst(INTL_GRP, BIS_INST);
			10: return op_inst(INTL_GRP, ORNOT_INST);
			11: return op_inst(INTL_GRP, XOR_INST);
			12: return op_inst(INTL_GRP, EQV_INST);
			13: return op_inst(INTS_GRP, SRL_INST);
			14: return op_inst(INTS_GRP, SLL_INST);
			15: return op_inst(INTS_GRP, SRA_INST);
			default: return op_inst(INTM_GRP, MULQ_INST);
		endcase
	endfunction

	function automatic inst_t seed_lda();
		return {LDA_INST, 5'(take_bits(5)), ZERO_REG, 16'(take_bits(16))};  // rX = sext(disp)
	endfunction

	function automatic inst_t mem_br_op();
		logic [5:0] opc;
		case (take_bits(4) % 11)
			0: opc = LDA_INST;
			1: opc = LDQ_INST;
			2: opc = STQ_INST;
			3: opc = BR_INST;
			4: opc = BSR_INST;
			5: opc = BEQ_INST;
			6: opc = BNE_INST;
			7: opc = BLT_INST;
			8: opc = BGE_INST;
			9: opc = BLBS_INST;
			default: opc = JSR_GRP;
		endcase
		if (opc[5:4] == 2'b11)
			return {opc, 5'(take_bits(5)), 21'(take_bits(21))};         // branch format
		return {opc, 5'(take_bits(5)), 5'(take_bits(5)), 16'(take_bits(16))};
	endfunction

	// ************************************************************************
	// reference model
	// ************************************************************************
	task automatic model_accept(inst_t inst);
		ret_pkt_t   e;
		logic [4:0] ra, rb;
		word_t      av, bv, ob, disp, bdisp;
		ra    = inst[25:21];
		rb    = inst[20:16];
		av    = (ra == 5'd31) ? 64'd0 : regs[ra];
		bv    = (rb == 5'd31) ? 64'd0 : regs[rb];
		ob    = inst[12] ? {56'd0, inst[20:13]} : bv;
		disp  = {{48{inst[15]}}, inst[15:0]};
		bdisp = {{41{inst[20]}}, inst[20:0], 2'b00};
		e     = '0;
		e.dest_idx = inst[4:0];
		e.fu_sel   = FU_ALU;
		case (inst[31:26])
			INTA_GRP:
				case (inst[11:5])
					ADDQ_INST:   e.value = av + ob;
					SUBQ_INST:   e.value = av - ob;
					CMPULT_INST: e.value = word_t'(av < ob);
					CMPEQ_INST:  e.value = word_t'(av == ob);
					CMPULE_INST: e.value = word_t'(av <= ob);
					CMPLT_INST:  e.value = word_t'($signed(av) < $signed(ob));
					CMPLE_INST:  e.value = word_t'($signed(av) <= $signed(ob));
					default:     e.illegal = 1'b1;
				endcase
			INTL_GRP:
				case (inst[11:5])
					AND_INST:    e.value = av & ob;
					BIC_INST:    e.value = av & ~ob;
					BIS_INST:    e.value = av | ob;
					ORNOT_INST:  e.value = av | ~ob;
					XOR_INST:    e.value = av ^ ob;
					EQV_INST:    e.value = ~(av ^ ob);
					default:     e.illegal = 1'b1;
				endcase
			INTS_GRP:
				case (inst[11:5])
					SRL_INST:    e.value = av >> ob[5:0];
					SLL_INST:    e.value = av << ob[5:0];
					SRA_INST:    e.value = word_t'($signed(av) >>> ob[5:0]);
					default:     e.illegal = 1'b1;
				endcase
			INTM_GRP:
			begin
				e.fu_sel = FU_MULT;
				e.value  = av * ob;
				e.illegal = (inst[11:5] != MULQ_INST);
			end
			LDA_INST, LDQ_INST, STQ_INST:
			begin
				e.value    = disp + bv;                        // base in rb
				e.dest_idx = ra;
				if (inst[31:26] == LDQ_INST)
					e.fu_sel = FU_LOAD;
				if (inst[31:26] == STQ_INST)
				begin
					e.fu_sel   = FU_STORE;
					e.dest_idx = ZERO_REG;
				end
			end
			BR_INST, BSR_INST:
			begin
				e.value    = av + bdisp;
				e.dest_idx = ra;
				e.fu_sel   = FU_UNCOND_BRANCH;
				e.taken    = 1'b1;
			end
			BEQ_INST, BNE_INST, BLT_INST, BLE_INST, BGT_INST, BGE_INST, BLBC_INST, BLBS_INST:
			begin
				e.value    = av + bdisp;
				e.dest_idx = ZERO_REG;
				e.fu_sel   = FU_COND_BRANCH;
				case (inst[31:26])
					BEQ_INST:  e.taken = (av == 0);
					BNE_INST:  e.taken = (av != 0);
					BLT_INST:  e.taken = $signed(av) < 0;
					BLE_INST:  e.taken = $signed(av) <= 0;
					BGT_INST:  e.taken = $signed(av) > 0;
					BGE_INST:  e.taken = $signed(av) >= 0;
					BLBC_INST: e.taken = !av[0];
					default:   e.taken = av[0];
				endcase
			end
			JSR_GRP:
			begin
				e.value    = bv & ~64'h3;                      // aligned target
				e.dest_idx = ra;
				e.fu_sel   = FU_UNCOND_BRANCH;
				e.taken    = 1'b1;
			end
			PAL_INST:
			begin
				e.fu_sel   = FU_NONE;
				e.dest_idx = ZERO_REG;
				if (inst[25:0] == PAL_HALT)
				begin
					e.halt  = 1'b1;
					e.value = av + bv;
				end
				else if (inst[25:0] == PAL_WHAMI)
				begin
					e.value    = CPU_ID;
					e.dest_idx = ra;
				end
				else
					e.illegal = 1'b1;
			end
			default: e.illegal = 1'b1;                      // fp and unknown
		endcase
		if (!e.illegal && e.dest_idx != ZERO_REG)
			regs[e.dest_idx] = e.value;
		exp_q.push_back(e);
	endtask

	// ************************************************************************
	// handshake driving, falling edge
	// ************************************************************************
	task automatic send(inst_t inst);
		logic done;
		done = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			inst_valid_i = 1'b1;
			inst_i       = inst;
			ret_ready_i  = stall_en ? 1'(take_bits(1)) : 1'b1;
			#1;
			if (inst_ready_o)
			begin
				model_accept(inst);
				done = 1'b1;
			end
			@(posedge clk);
		end
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		inst_valid_i = 1'b0;
		ret_ready_i  = stall_en ? 1'(take_bits(1)) : 1'b1;
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			idle_cycle();
		idle_cycle();
	endtask

	task automatic report_test(string name, int errs_before, int recs_before);
		drain();
		$display("test %s: %0d records, %0d errors", name, rec_cnt - recs_before,
			err_cnt - errs_before);
	endtask

	task automatic check_field(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp)
		begin
			$display("Error: %s got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	// retire monitor, compares against the model queue
	always @(posedge clk)
	begin
		ret_pkt_t e;
		if (rst_n_i && ret_valid_o && ret_ready_i)
		begin
			rec_cnt++;
			if (exp_q.size() == 0)
			begin
				$display("a record retired that no accepted instruction produced");
				err_cnt++;
			end
			else
			begin
				e = exp_q.pop_front();
				check_field("illegal", 64'(ret_o.illegal), 64'(e.illegal));
				if (!e.illegal)                            // value undefined when illegal
				begin
					check_field("dest_idx", 64'(ret_o.dest_idx), 64'(e.dest_idx));
					check_field("value", ret_o.value, e.value);
					check_field("fu_sel", 64'(ret_o.fu_sel), 64'(e.fu_sel));
					check_field("taken", 64'(ret_o.taken), 64'(e.taken));
					check_field("halt", 64'(ret_o.halt), 64'(e.halt));
				end
			end
		end
	end

	initial
	begin
		int e0;
		int r0;
		inst_valid_i = 1'b0;
		inst_i       = '0;
		ret_ready_i  = 1'b1;
		rst_n_i      = 1'b0;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		repeat (10) @(negedge clk);
		rst_n_i = 1'b1;

		e0 = err_cnt;
		r0 = rec_cnt;
		for (int i = 0; i < N_INT; i++)
			send((i < 16) ? seed_lda() : int_op(take_bits(5) % 17));
		report_test("integer ops", e0, r0);

		e0 = err_cnt;
		r0 = rec_cnt;
		for (int i = 0; i < N_MEM; i++)
			send(mem_br_op());
		report_test("memory and branch", e0, r0);

		e0 = err_cnt;
		r0 = rec_cnt;
		for (int i = 0; i < N_SPEC / 5; i++)
		begin
			send({6'h16, 26'(take_bits(26))});              // fp group
			send({INTA_GRP, 5'(take_bits(5)), 5'(take_bits(5)), 4'b0000, 7'h7f,
				5'(take_bits(5))});
			send({PAL_INST, PAL_WHAMI});
			send({INTA_GRP, 5'(take_bits(5)), 8'h5a, 1'b1, ADDQ_INST, ZERO_REG});  // to r31
			send(int_op(9));
		end
		report_test("illegal and special", e0, r0);

		e0 = err_cnt;
		r0 = rec_cnt;
		stall_en = 1'b1;
		for (int i = 0; i < N_BP; i++)
			send(int_op(take_bits(5) % 17));
		report_test("back-pressure", e0, r0);
		stall_en = 1'b0;

		e0 = err_cnt;
		r0 = rec_cnt;
		send({PAL_INST, PAL_HALT});
		while (!halted_o)
			idle_cycle();
		repeat (4)
		begin
			idle_cycle();
			#1;
			if (inst_ready_o)
			begin
				$display("the core accepted input after it halted");
				err_cnt++;
			end
		end
		@(negedge clk);
		rst_n_i = 1'b0;
		repeat (10) @(negedge clk);
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		exp_q.delete();
		rst_n_i = 1'b1;
		for (int i = 0; i < N_HALT - 1; i++)
			send((i < 4) ? seed_lda() : int_op(take_bits(5) % 17));
		report_test("halt and reset", e0, r0);

		$display("%0d records checked, %0d errors, %0d assertion failures", rec_cnt, err_cnt,
			dut.u_asserts.fail_cnt);
		if (err_cnt == 0 && dut.u_asserts.fail_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== int_core.f ====
hdl/alpha_pkg.sv
hdl/inst_decoder.sv
hdl/id_stage.sv
hdl/reg_file.sv
hdl/ex_stage.sv
hdl/wb_stage.sv
hdl/int_core.sv
verif/int_core_asserts.sv
verif/int_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the integer core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f int_core.f --top-module int_core_tb -o int_core_sim &&
	./obj_dir/int_core_sim | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
